//--- include/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Boot address the fetch unit starts from
`define FETCH_RESET_PC 32'h30000000

// Instruction ROM depth in 32-bit words
`define FETCH_ROM_WORDS 256

// Cycles from address handshake to read data
`define FETCH_READ_LATENCY 3

`endif

//--- hw/fetch_pkg.sv
package fetch_pkg;

    // --------------------
    // Basic types
    // --------------------
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;

    // AXI read response, only the two codes this bus produces
    typedef logic [1:0] resp_t;
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // --------------------
    // Channel payloads
    // --------------------

    // Read data channel, rready is implied high
    typedef struct packed {
        inst_t data;
        resp_t resp;
    } rd_data_t;

    // Control flow request from the later stages
    typedef struct packed {
        addr_t target;
        logic  jump;
        logic  stop;
    } redirect_t;

    // Packet handed to decode
    typedef struct packed {
        addr_t pc;
        inst_t inst;
        logic  fault;
    } fetch_pkt_t;

    // --------------------
    // ROM contents
    // --------------------

    // Word pattern at a given word index, shared by ROM and model
    function automatic inst_t rom_word(input logic [31:0] index);
        return (index * 32'h9e3779b1) ^ 32'h00000013;
    endfunction

endpackage

//--- hw/ifu.sv
module ifu #(
    parameter fetch_pkg::addr_t RESET_PC = '0
) (
    input  logic                  clock,
    input  logic                  reset,

    // Redirect from the later stages
    input  fetch_pkg::redirect_t  redir,

    // AXI read address channel
    output logic                  arvalid,
    input  logic                  arready,
    output fetch_pkg::addr_t      araddr,

    // AXI read data channel
    input  logic                  rvalid,
    input  fetch_pkg::rd_data_t   rdata,

    // Decode side
    output logic                  out_valid,
    input  logic                  out_ready,
    output fetch_pkg::fetch_pkt_t out_pkt,

    // Performance counter
    output logic [31:0]           fetch_count
);

    import fetch_pkg::*;

    addr_t     pc;
    addr_t     next_pc;
    redirect_t redir_q;
    logic      redir_held;
    logic      handoff;

    assign handoff    = out_valid && out_ready;
    assign redir_held = redir_q.jump || redir_q.stop;

    // Fetch address is always the current PC
    assign araddr = pc;

    // --------------------
    // Redirect latch
    // --------------------

    // Captures a redirect that shows up while the packet is not yet taken,
    // so it still applies at the handoff even if the live one is gone
    always_ff @(posedge clock) begin
        if (reset) begin
            redir_q.jump <= 1'b0;
            redir_q.stop <= 1'b0;
        end else if (handoff) begin
            redir_q.jump <= 1'b0;
            redir_q.stop <= 1'b0;
        end else if (!redir_held) begin
            redir_q <= redir;
        end
    end

    // --------------------
    // Program counter
    // --------------------

    // Stop beats latched jump beats live jump beats sequential
    always_comb begin
        if (redir.stop || redir_q.stop) begin
            next_pc = pc;
        end else if (redir_q.jump) begin
            next_pc = redir_q.target;
        end else if (redir.jump) begin
            next_pc = redir.target;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (handoff) begin
            pc <= next_pc;
        end
    end

    // --------------------
    // Read request
    // --------------------

    // One fetch in flight; next request only after decode takes the packet
    always_ff @(posedge clock) begin
        if (reset) begin
            arvalid <= 1'b1;
        end else if (handoff) begin
            arvalid <= 1'b1;
        end else if (arvalid && arready) begin
            arvalid <= 1'b0;
        end
    end

    // --------------------
    // Output register
    // --------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (rvalid) begin
            out_valid <= 1'b1;
        end else if (handoff) begin
            out_valid <= 1'b0;
        end
    end

    // PC still points at the fetched word until the handoff
    always_ff @(posedge clock) begin
        if (rvalid) begin
            out_pkt.pc <= pc;
            if (rdata.resp == RESP_OKAY) begin
                out_pkt.inst  <= rdata.data;
                out_pkt.fault <= 1'b0;
            end else begin
                // Access fault, no instruction bits passed on
                out_pkt.inst  <= '0;
                out_pkt.fault <= 1'b1;
            end
        end
    end

    // Fetched words, faults included
    always_ff @(posedge clock) begin
        if (reset) begin
            fetch_count <= '0;
        end else if (rvalid) begin
            fetch_count <= fetch_count + 32'd1;
        end
    end

endmodule

//--- hw/inst_rom.sv
module inst_rom #(
    parameter int ROM_WORDS    = 1,
    parameter int READ_LATENCY = 1
) (
    input  logic                clock,
    input  logic                reset,

    // AXI read address channel
    input  logic                arvalid,
    output logic                arready,
    input  fetch_pkg::addr_t    araddr,

    // AXI read data channel
    output logic                rvalid,
    output fetch_pkg::rd_data_t rdata
);

    import fetch_pkg::*;

    localparam int IDX_W = (ROM_WORDS > 1) ? $clog2(ROM_WORDS) : 1;
    localparam int CNT_W = (READ_LATENCY > 1) ? $clog2(READ_LATENCY) : 1;

    inst_t            mem [ROM_WORDS];
    logic             busy;
    logic [CNT_W-1:0] delay_cnt;
    logic [IDX_W-1:0] idx_q;
    logic             err_q;
    logic             in_range;

    // --------------------
    // Contents
    // --------------------
    initial begin
        for (int i = 0; i < ROM_WORDS; i++) begin
            mem[i] = rom_word(32'(i));
        end
    end

    // Word index is the byte address over four
    assign in_range = (araddr >> 2) < 32'(ROM_WORDS);

    // Idle means ready to take an address
    assign arready = !busy;

    // --------------------
    // Latency control
    // --------------------

    // Countdown loaded at the handshake, response fires when it hits zero
    always_ff @(posedge clock) begin
        if (reset) begin
            busy      <= 1'b0;
            delay_cnt <= '0;
            rvalid    <= 1'b0;
        end else begin
            rvalid <= 1'b0;
            if (!busy) begin
                if (arvalid) begin
                    busy      <= 1'b1;
                    delay_cnt <= CNT_W'(READ_LATENCY - 1);
                end
            end else if (delay_cnt == '0) begin
                busy   <= 1'b0;
                rvalid <= 1'b1;
            end else begin
                delay_cnt <= delay_cnt - 1'b1;
            end
        end
    end

    // Address and range result held for the whole read
    always_ff @(posedge clock) begin
        if (arvalid && arready) begin
            idx_q <= araddr[IDX_W+1:2];
            err_q <= !in_range;
        end
    end

    // Read data, zero with SLVERR when out of range
    always_ff @(posedge clock) begin
        if (busy && delay_cnt == '0) begin
            if (err_q) begin
                rdata.data <= '0;
                rdata.resp <= RESP_SLVERR;
            end else begin
                rdata.data <= mem[idx_q];
                rdata.resp <= RESP_OKAY;
            end
        end
    end

endmodule

//--- hw/fetch_top.sv
`include "fetch_defs.svh"

module fetch_top #(
    parameter fetch_pkg::addr_t RESET_PC     = `FETCH_RESET_PC,
    parameter int               ROM_WORDS    = `FETCH_ROM_WORDS,
    parameter int               READ_LATENCY = `FETCH_READ_LATENCY
) (
    input  logic                  clock,
    input  logic                  reset,

    // Redirect from the later stages
    input  fetch_pkg::redirect_t  redir,

    // Decode side
    output logic                  out_valid,
    input  logic                  out_ready,
    output fetch_pkg::fetch_pkt_t out_pkt,

    // Fetched word count
    output logic [31:0]           fetch_count
);

    import fetch_pkg::*;

    // --------------------
    // Read channel
    // --------------------
    logic     arvalid;
    logic     arready;
    addr_t    araddr;
    logic     rvalid;
    rd_data_t rdata;

    ifu #(
        .RESET_PC (RESET_PC)
    ) ifu_inst (
        .clock       (clock),
        .reset       (reset),
        .redir       (redir),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_pkt     (out_pkt),
        .fetch_count (fetch_count)
    );

    inst_rom #(
        .ROM_WORDS    (ROM_WORDS),
        .READ_LATENCY (READ_LATENCY)
    ) inst_rom_inst (
        .clock   (clock),
        .reset   (reset),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rdata   (rdata)
    );

endmodule

//--- verif/fetch_tb_model.sv
package fetch_tb_model;

    import fetch_pkg::*;

    // --------------------
    // Reference state
    // --------------------

    // Program counter and the redirect held back for the next handoff
    typedef struct packed {
        addr_t     pc;
        redirect_t held;
    } model_state_t;

    function automatic model_state_t reset_model(input addr_t reset_pc);
        model_state_t state;
        state.pc   = reset_pc;
        state.held = '0;
        return state;
    endfunction

    // One rising clock edge of the fetch sequence
    function automatic model_state_t step_model(
        input model_state_t state,
        input redirect_t    live,
        input logic         handoff
    );
        model_state_t next;
        next = state;
        if (handoff) begin
            // Stop first, then the held jump, then the live one
            if (live.stop || state.held.stop) begin
                next.pc = state.pc;
            end else if (state.held.jump) begin
                next.pc = state.held.target;
            end else if (live.jump) begin
                next.pc = live.target;
            end else begin
                next.pc = state.pc + 32'd4;
            end
            next.held.jump = 1'b0;
            next.held.stop = 1'b0;
        end else if (!(state.held.jump || state.held.stop)) begin
            next.held = live;
        end
        return next;
    endfunction

    // Packet for a fetch from pc, an access fault past the last ROM word
    function automatic fetch_pkt_t expect_pkt(input addr_t pc, input int rom_words);
        fetch_pkt_t  pkt;
        logic [31:0] index;
        index  = pc >> 2;
        pkt.pc = pc;
        if (index < 32'(rom_words)) begin
            pkt.inst  = rom_word(index);
            pkt.fault = 1'b0;
        end else begin
            pkt.inst  = '0;
            pkt.fault = 1'b1;
        end
        return pkt;
    endfunction

    // --------------------
    // Compare tasks
    // --------------------

    task automatic compare_pkt(
        input  string      name,
        input  fetch_pkt_t expected,
        input  fetch_pkt_t actual,
        output logic       ok
    );
        ok = (actual === expected);
        if (!ok) begin
            $display("ERROR %s expected pc %h inst %h fault %h", name,
                     expected.pc, expected.inst, expected.fault);
            $display("ERROR %s actual   pc %h inst %h fault %h", name,
                     actual.pc, actual.inst, actual.fault);
        end
    endtask

    task automatic compare_count(
        input  string       name,
        input  logic [31:0] expected,
        input  logic [31:0] actual,
        output logic        ok
    );
        ok = (actual === expected);
        if (!ok) begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic compare_valid(
        input  string name,
        input  logic  expected,
        input  logic  actual,
        output logic  ok
    );
        ok = (actual === expected);
        if (!ok) begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
        end
    endtask

endpackage

//--- verif/fetch_tb.sv
`include "fetch_defs.svh"

module fetch_tb;

    import fetch_pkg::*;
    import fetch_tb_model::*;

    localparam addr_t       RESET_PC       = `FETCH_RESET_PC;
    localparam int          ROM_WORDS      = `FETCH_ROM_WORDS;
    localparam int          READ_LATENCY   = `FETCH_READ_LATENCY;
    localparam int          NUM_HANDOFFS   = 1500;
    // Edges from a handoff, or from reset, to the next out_valid
    localparam int          FETCH_CYCLES   = READ_LATENCY + 2;
    localparam int          TIMEOUT_CYCLES = NUM_HANDOFFS * FETCH_CYCLES * 10 + 1000;
    localparam logic [31:0] SEED           = 32'h49a9;

    logic        clock;
    logic        reset;
    redirect_t   redir;
    logic        out_valid;
    logic        out_ready;
    fetch_pkt_t  out_pkt;
    logic [31:0] fetch_count;

    logic [31:0] handoff_count;

    fetch_top fetch_top_inst (
        .clock       (clock),
        .reset       (reset),
        .redir       (redir),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_pkt     (out_pkt),
        .fetch_count (fetch_count)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #5 clock = ~clock;
        end
    end

    task automatic stop_on_error();
        $display("TEST FAILED");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    // --------------------
    // Stimulus
    // --------------------

    // New decode-side and redirect levels for the next rising edge
    task automatic drive_random();
        logic [31:0] word_index;
        out_ready  = ($urandom % 10) < 7;
        redir.jump = ($urandom % 10) == 0;
        redir.stop = ($urandom % 20) == 0;
        if (($urandom % 8) == 0) begin
            // Somewhere past the last ROM word
            word_index = 32'(ROM_WORDS) + ($urandom % 32'd4096);
        end else begin
            word_index = $urandom % 32'(ROM_WORDS);
        end
        redir.target = {word_index[29:0], 2'b00};
    endtask

    initial begin
        model_state_t state;
        redirect_t    live;
        logic         ready;
        logic         handoff;
        logic         exp_valid;
        int           wait_cycles;
        logic         ok;

        reset         = 1'b1;
        out_ready     = 1'b0;
        redir         = '0;
        handoff_count = '0;
        void'($urandom(SEED));

        repeat (16) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        compare_valid("out_valid", 1'b0, out_valid, ok);
        if (!ok) stop_on_error();

        state       = reset_model(RESET_PC);
        exp_valid   = 1'b0;
        wait_cycles = 0;

        while (handoff_count < 32'(NUM_HANDOFFS)) begin
            drive_random();
            live    = redir;
            ready   = out_ready;
            handoff = exp_valid && ready;
            @(negedge clock);

            // Outputs have settled from the rising edge just passed
            if (handoff) begin
                handoff_count = handoff_count + 32'd1;
                exp_valid     = 1'b0;
                wait_cycles   = 0;
            end else if (!exp_valid) begin
                wait_cycles++;
                if (wait_cycles == FETCH_CYCLES) begin
                    exp_valid = 1'b1;
                end
            end
            state = step_model(state, live, handoff);

            compare_valid("out_valid", exp_valid, out_valid, ok);
            if (!ok) stop_on_error();

            // Also covers the hold while out_ready is low
            if (exp_valid) begin
                compare_pkt("out_pkt", expect_pkt(state.pc, ROM_WORDS), out_pkt, ok);
                if (!ok) stop_on_error();
            end

            compare_count("fetch_count", handoff_count + {31'd0, exp_valid},
                          fetch_count, ok);
            if (!ok) stop_on_error();
        end

        $display("TEST OK");
        $finish;
    end

    // --------------------
    // Timeout
    // --------------------
    initial begin
        int cycle_count;
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("No handoff arrived in time, %0d of %0d handoffs after %0d cycles",
                 handoff_count, NUM_HANDOFFS, cycle_count);
        $display("TEST FAILED");
        $fatal(1, "Cycle limit reached");
    end

endmodule

//--- sim.f
+incdir+include
hw/fetch_pkg.sv
hw/ifu.sv
hw/inst_rom.sv
hw/fetch_top.sv
verif/fetch_tb_model.sv
verif/fetch_tb.sv

//--- run.sh
#!/bin/sh
# Build the fetch stage testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f sim.f --top-module fetch_tb -o fetch_sim \
    && ./obj_dir/fetch_sim > sim.log 2>&1 \
    || echo "Build or simulation returned an error"

test -f sim.log && cat sim.log
test -f sim.log && ! grep -q "TEST FAILED" sim.log && grep -q "TEST OK" sim.log
